// File: bench/correlator_asserts.sv
// concurrent checks on the write arbiter and the output handshake
`timescale 1ns/1ps
`default_nettype none

module correlator_asserts (
	input wire logic pllclk,
	input wire logic reset,
	input wire logic c_req,
	input wire logic c_gnt,
	input wire logic a_req,
	input wire logic a_gnt,
	input wire logic rd_release,
	input wire logic out_valid,
	input wire logic out_ready,
	input wire logic [31:0] out_data,
	input wire logic out_last
);

	// round robin under contention, both directions
	gnt_alternates: assert property (@(posedge pllclk) disable iff (!reset)
		(c_req && a_req && $past(c_req && a_req)) |-> (c_gnt != $past(c_gnt)))
		else $error("arbiter did not alternate");

	out_held: assert property (@(posedge pllclk) disable iff (!reset)
		$past(out_valid && !out_ready) |-> (out_valid && $stable(out_data)
			&& $stable(out_last)))
		else $error("output word changed while stalled");

	// nothing left to show once the bank goes back
	release_ends_frame: assert property (@(posedge pllclk) disable iff (!reset)
		rd_release |=> !out_valid)
		else $error("out_valid still high after the bank was released");

endmodule

`default_nettype wire

// File: bench/correlator_tb.sv
// correlator testbench: frame table, lcg stimulus, reference model, checks and summary
`timescale 1ns/1ps
`default_nettype none

`include "corr_config.svh"

module correlator_tb import corr_sample_pkg::*, corr_frame_pkg::*; ();

	localparam int NROWS = 7;
	localparam int NW = `CORR_FRAME_WORDS;
	localparam int M_RAND = 0;
	localparam int M_MAX = 1;
	localparam int M_ZERO = 2;
	localparam int R_ALL = 0;
	localparam int R_RAND = 1;
	localparam int R_STALL = 2;
	localparam int STALL_CYCLES = 100;  // long enough to block the next-but-one frame

	int row_len [NROWS] = '{40, 48, 600, 40, 40, 40, 48};
	int row_mode [NROWS] = '{M_RAND, M_RAND, M_MAX, M_RAND, M_ZERO, M_RAND, M_RAND};
	int row_ready [NROWS] = '{R_ALL, R_RAND, R_ALL, R_STALL, R_ALL, R_ALL, R_RAND};
	bit row_drop [NROWS] = '{0, 0, 0, 0, 0, 1, 0};

	logic pllclk = 1'b0;
	logic reset;
	logic smp_valid;
	lane_samples_t samples;
	count_t int_len;
	logic out_ready;
	logic out_valid;
	word_t out_data;
	logic out_last;

	int hist [`CORR_INPUTS][3];  // model delay line per input
	int macc [NW];
	bit msat [NW];
	word_t exp_words [NROWS][NW];
	bit exp_valid [NROWS];
	logic [31:0] rnd_smp, rnd_ready;
	int err_data, err_proto, cycles, limit;

	correlator_top i_dut (.pllclk, .reset, .smp_valid, .samples, .int_len,
		.out_ready, .out_valid, .out_data, .out_last);

	bind correlator_top correlator_asserts i_asserts (.pllclk, .reset, .c_req, .c_gnt,
		.a_req, .a_gnt, .rd_release, .out_valid, .out_ready, .out_data, .out_last);

	always #5 pllclk = ~pllclk;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int next_row(input int r);
		int k;
		k = r;
		while (k < NROWS && row_drop[k])
			k++;
		return k;
	endfunction

	function automatic int drops_before(input int r);
		int n;
		n = 0;
		for (int k = 0; k < r; k++)
			if (row_drop[k])
				n++;
		return n;
	endfunction

	// one sample through the model; last closes the frame of row r
	task automatic model_sample(input int r, input lane_samples_t lanes, input bit last);
		int prod [NW];
		int bl, sum;
		sample_t v;
		for (int i = 0; i < `CORR_INPUTS; i++) begin
			v = lanes[i*`CORR_SAMPLE_W +: `CORR_SAMPLE_W];
			hist[i][2] = hist[i][1];
			hist[i][1] = hist[i][0];
			hist[i][0] = int'(v);
		end
		bl = 0;
		for (int a = 0; a < `CORR_INPUTS; a++) begin
			for (int b = a + 1; b < `CORR_INPUTS; b++) begin
				for (int l = 0; l < 3; l++)
					prod[bl*3 + l] = hist[a][1] * hist[b][l];
				bl++;
			end
		end
		for (int i = 0; i < `CORR_INPUTS; i++)
			prod[`CORR_CROSS_WORDS + i] = hist[i][0] * hist[i][0];
		for (int k = 0; k < NW; k++) begin
			if (last) begin
				exp_words[r][k] = {msat[k], 15'd0, 16'(macc[k])};
				macc[k] = prod[k];  // seeds the next frame
				msat[k] = 1'b0;
			end else if (!msat[k]) begin
				sum = macc[k] + prod[k];
				if (sum > 32767) begin
					macc[k] = 32767;
					msat[k] = 1'b1;
				end else if (sum < -32768) begin
					macc[k] = -32768;
					msat[k] = 1'b1;
				end else begin
					macc[k] = sum;
				end
			end
		end
		if (last)
			exp_valid[r] = 1'b1;
	endtask

	task automatic drive_samples();
		lane_samples_t lanes;
		for (int r = 0; r < NROWS; r++) begin
			for (int s = 1; s <= row_len[r]; s++) begin
				rnd_smp = lcg(rnd_smp);
				case (row_mode[r])
					M_RAND: lanes = rnd_smp[31:16];
					M_MAX: lanes = {`CORR_INPUTS{4'h8}};  // largest magnitude
					default: lanes = '0;
				endcase
				@(posedge pllclk);
				smp_valid <= 1'b1;
				samples <= lanes;
				int_len <= count_t'(row_len[r]);
				model_sample(r, lanes, s == row_len[r]);
				@(posedge pllclk);
				smp_valid <= 1'b0;
			end
		end
	endtask

	task automatic check_word(input int r, input int w, input word_t got, input logic last);
		word_t exp;
		if (w == 0)
			exp = {8'h00, 8'(drops_before(r)), 16'(r)};
		else
			exp = exp_words[r][w-1];
		if (got !== exp) begin
			err_data++;
			$display("Fail out_data frame %0d word %0d: got %h expected %h", r, w, got, exp);
		end
		if (w > 0 && row_mode[r] == M_MAX && got !== 32'h80007fff) begin
			err_data++;
			$display("Fail out_data frame %0d word %0d: got %h expected %h",
				r, w, got, 32'h80007fff);
		end
		if (last !== (w == NW)) begin
			err_data++;
			$display("Fail out_last frame %0d word %0d: got %h expected %h",
				r, w, last, (w == NW));
		end
	endtask

	function automatic logic ready_for(input int r, input int stall_cnt);
		if (r >= NROWS)
			return 1'b1;
		if (row_ready[r] == R_STALL)
			return stall_cnt >= STALL_CYCLES;
		if (row_ready[r] == R_RAND) begin
			rnd_ready = lcg(rnd_ready);
			return rnd_ready[17:16] != 2'b00;  // ready three times in four
		end
		return 1'b1;
	endfunction

	task automatic receive_frames();
		int r, w, stall_cnt;
		r = next_row(0);
		w = 0;
		stall_cnt = 0;
		while (r < NROWS) begin
			@(posedge pllclk);
			if (out_valid && !exp_valid[0]) begin
				err_proto++;
				$display("out_valid went high before the first frame ended");
			end
			if (out_valid && out_ready) begin
				check_word(r, w, out_data, out_last);
				if (w == NW) begin
					w = 0;
					stall_cnt = 0;
					r = next_row(r + 1);
				end else begin
					w++;
				end
			end else if (out_valid) begin
				stall_cnt++;
			end
			out_ready <= ready_for(r, stall_cnt);
		end
	endtask

	always @(posedge pllclk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("errors: data %0d, protocol %0d", err_data, err_proto + 1);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		reset <= 1'b0;
		smp_valid <= 1'b0;
		samples <= '0;
		int_len <= count_t'(row_len[0]);
		out_ready <= 1'b1;
		rnd_smp = 32'hf08b;
		rnd_ready = 32'hf08b;
		err_data = 0;
		err_proto = 0;
		cycles <= 0;
		limit = 0;
		for (int r = 0; r < NROWS; r++)
			limit += row_len[r] * 2 + 100;
		for (int i = 0; i < `CORR_INPUTS; i++)
			for (int d = 0; d < 3; d++)
				hist[i][d] = 0;
		for (int k = 0; k < NW; k++) begin
			macc[k] = 0;
			msat[k] = 1'b0;
		end
		for (int r = 0; r < NROWS; r++)
			exp_valid[r] = 1'b0;
		repeat (16) @(posedge pllclk);
		reset <= 1'b1;
		fork
			drive_samples();
			receive_frames();
		join
		$display("errors: data %0d, protocol %0d", err_data, err_proto);
		if (err_data == 0 && err_proto == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/auto_engine.sv
// per-input power accumulators, frame snapshot and dump fsm
`timescale 1ns/1ps
`default_nettype none

`include "corr_config.svh"

module auto_engine import corr_sample_pkg::*, corr_frame_pkg::*; (
	input wire logic pllclk,
	input wire logic reset,
	input wire logic tap_valid,
	input wire logic frame_end,
	input wire tap_t [`CORR_INPUTS-1:0] taps,
	output logic wr_req,
	output addr_t wr_addr,
	output word_t wr_data,
	input wire logic wr_gnt,
	output logic done_pulse
);

	acc_t sq [`CORR_AUTO_WORDS];
	acc_t acc [`CORR_AUTO_WORDS];
	logic sat [`CORR_AUTO_WORDS];
	acc_t snap_acc [`CORR_AUTO_WORDS];
	logic snap_sat [`CORR_AUTO_WORDS];

	dump_state_t state;
	logic [$clog2(`CORR_AUTO_WORDS)-1:0] idx;

	for (genvar i = 0; i < `CORR_AUTO_WORDS; i++) begin : g_sq
		assign sq[i] = acc_t'(tap_at(taps[i], 0)) * acc_t'(tap_at(taps[i], 0));
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int i = 0; i < `CORR_AUTO_WORDS; i++) begin
				acc[i] <= '0;
				sat[i] <= 1'b0;
			end
		end else if (tap_valid) begin
			for (int i = 0; i < `CORR_AUTO_WORDS; i++) begin
				if (frame_end) begin
					acc[i] <= sq[i];
					sat[i] <= 1'b0;
				end else if (!sat[i]) begin
					{sat[i], acc[i]} <= sat_add(acc[i], sq[i]);  // sticks once saturated
				end
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (tap_valid && frame_end) begin
			snap_acc <= acc;
			snap_sat <= sat;
		end
	end

	assign wr_req = (state == DUMP);
	assign done_pulse = (state == DONE);
	assign wr_addr = addr_t'(idx) + addr_t'(`CORR_CROSS_WORDS);  // after the cross block
	assign wr_data = make_word(snap_acc[idx], snap_sat[idx]);

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= IDLE;
			idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (tap_valid && frame_end) begin
						state <= DUMP;
						idx <= '0;
					end
				end
				DUMP: begin
					if (wr_gnt) begin
						if (idx == ($bits(idx))'(`CORR_AUTO_WORDS - 1))
							state <= DONE;
						else
							idx <= idx + 1'b1;
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/corr_config.svh
// correlator dimensions: inputs, sample width, lags, accumulator width, frame layout
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

`define CORR_INPUTS      4
`define CORR_SAMPLE_W    4
`define CORR_LAGS        3    // lags -1, 0, +1
`define CORR_ACC_W       16   // small enough to hit saturation quickly

// six pairs out of four inputs
`define CORR_BASELINES   6
`define CORR_CROSS_WORDS 18
`define CORR_AUTO_WORDS  4

// payload words per frame, header excluded
`define CORR_FRAME_WORDS 22
`define CORR_ADDR_W      5

`endif

// File: logic/corr_frame_pkg.sv
// accumulator, frame word, address, bank and fsm types with saturating add and word packing
`default_nettype none

`include "corr_config.svh"

package corr_frame_pkg;

	typedef logic signed [`CORR_ACC_W-1:0] acc_t;
	typedef logic [31:0] word_t;
	typedef logic [`CORR_ADDR_W-1:0] addr_t;
	typedef logic bank_t;
	typedef logic [15:0] frame_num_t;
	typedef logic [7:0] drop_t;

	typedef enum logic [1:0] {IDLE, DUMP, DONE} dump_state_t;
	typedef enum logic [1:0] {WAIT, HEADER, PAYLOAD} read_state_t;

	// returns {overflow, result}, result clamped to the acc_t range
	function automatic logic [`CORR_ACC_W:0] sat_add(acc_t acc, acc_t inc);
		logic [`CORR_ACC_W:0] sum;
		sum = {acc[`CORR_ACC_W-1], acc} + {inc[`CORR_ACC_W-1], inc};
		if (sum[`CORR_ACC_W] != sum[`CORR_ACC_W-1])
			return {1'b1, sum[`CORR_ACC_W], {(`CORR_ACC_W-1){~sum[`CORR_ACC_W]}}};
		return {1'b0, sum[`CORR_ACC_W-1:0]};
	endfunction

	function automatic word_t make_word(acc_t acc, logic sat);
		logic signed [15:0] ext;
		ext = 16'(acc);
		return {sat, 15'd0, ext};
	endfunction

endpackage

`default_nettype wire

// File: logic/corr_sample_pkg.sv
// sample, lane, tap, baseline, lag and count types plus tap extraction
`default_nettype none

`include "corr_config.svh"

package corr_sample_pkg;

	typedef logic signed [`CORR_SAMPLE_W-1:0] sample_t;
	typedef logic [`CORR_INPUTS*`CORR_SAMPLE_W-1:0] lane_samples_t;  // lane i at i*W
	typedef logic [3*`CORR_SAMPLE_W-1:0] tap_t;  // delay d at d*W
	typedef logic [2:0] baseline_t;
	typedef logic [1:0] lag_t;
	typedef logic [15:0] count_t;

	function automatic sample_t tap_at(tap_t t, int d);
		return sample_t'(t[d*`CORR_SAMPLE_W +: `CORR_SAMPLE_W]);
	endfunction

endpackage

`default_nettype wire

// File: logic/correlator_top.sv
// correlator top: front end, cross and auto engines, frame store and reader
`timescale 1ns/1ps
`default_nettype none

`include "corr_config.svh"

module correlator_top import corr_sample_pkg::*, corr_frame_pkg::*; (
	input wire logic pllclk,
	input wire logic reset,
	input wire logic smp_valid,
	input wire lane_samples_t samples,
	input wire count_t int_len,
	input wire logic out_ready,
	output logic out_valid,
	output word_t out_data,
	output logic out_last
);

	logic tap_valid, frame_end;
	tap_t [`CORR_INPUTS-1:0] taps;

	logic c_req, c_gnt, c_done;
	addr_t c_addr;
	word_t c_data;
	logic a_req, a_gnt, a_done;
	addr_t a_addr;
	word_t a_data;

	logic bank_full, rd_release;
	addr_t rd_addr;
	word_t rd_data;
	frame_num_t frame_num;
	drop_t drop_count;

	sample_front i_front (.pllclk, .reset, .smp_valid, .samples, .int_len,
		.tap_valid, .taps, .frame_end);

	cross_engine i_cross (.pllclk, .reset, .tap_valid, .frame_end, .taps,
		.wr_req(c_req), .wr_addr(c_addr), .wr_data(c_data), .wr_gnt(c_gnt),
		.done_pulse(c_done));

	auto_engine i_auto (.pllclk, .reset, .tap_valid, .frame_end, .taps,
		.wr_req(a_req), .wr_addr(a_addr), .wr_data(a_data), .wr_gnt(a_gnt),
		.done_pulse(a_done));

	frame_store i_store (.pllclk, .reset,
		.c_req, .c_addr, .c_data, .c_gnt, .a_req, .a_addr, .a_data, .a_gnt,
		.c_done, .a_done, .bank_full, .rd_addr, .rd_data, .rd_release,
		.frame_num, .drop_count);

	frame_reader i_reader (.pllclk, .reset, .bank_full, .rd_addr, .rd_data,
		.frame_num, .drop_count, .rd_release, .out_valid, .out_data, .out_last,
		.out_ready);

endmodule

`default_nettype wire

// File: logic/cross_engine.sv
// baseline and lag multiply-accumulators, frame snapshot and dump fsm
`timescale 1ns/1ps
`default_nettype none

`include "corr_config.svh"

module cross_engine import corr_sample_pkg::*, corr_frame_pkg::*; (
	input wire logic pllclk,
	input wire logic reset,
	input wire logic tap_valid,
	input wire logic frame_end,
	input wire tap_t [`CORR_INPUTS-1:0] taps,
	output logic wr_req,
	output addr_t wr_addr,
	output word_t wr_data,
	input wire logic wr_gnt,
	output logic done_pulse
);

	acc_t prod [`CORR_CROSS_WORDS];
	acc_t acc [`CORR_CROSS_WORDS];
	logic sat [`CORR_CROSS_WORDS];
	acc_t snap_acc [`CORR_CROSS_WORDS];
	logic snap_sat [`CORR_CROSS_WORDS];

	dump_state_t state;
	baseline_t bl_ptr;
	lag_t lag_ptr;

	// pair (a,b) maps to baseline a*(2N-a-1)/2 + b-a-1
	for (genvar a = 0; a < `CORR_INPUTS; a++) begin : g_a
		for (genvar b = a + 1; b < `CORR_INPUTS; b++) begin : g_b
			localparam int BL = a * (2 * `CORR_INPUTS - a - 1) / 2 + b - a - 1;
			for (genvar l = 0; l < `CORR_LAGS; l++) begin : g_l
				// a fixed at delay 1, b slides over delays 0..2
				assign prod[BL * `CORR_LAGS + l] =
					acc_t'(tap_at(taps[a], 1)) * acc_t'(tap_at(taps[b], l));
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int i = 0; i < `CORR_CROSS_WORDS; i++) begin
				acc[i] <= '0;
				sat[i] <= 1'b0;
			end
		end else if (tap_valid) begin
			for (int i = 0; i < `CORR_CROSS_WORDS; i++) begin
				if (frame_end) begin
					acc[i] <= prod[i];  // current product opens the new frame
					sat[i] <= 1'b0;
				end else if (!sat[i]) begin
					{sat[i], acc[i]} <= sat_add(acc[i], prod[i]);
				end
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (tap_valid && frame_end) begin
			snap_acc <= acc;
			snap_sat <= sat;
		end
	end

	assign wr_req = (state == DUMP);
	assign done_pulse = (state == DONE);
	assign wr_addr = addr_t'(bl_ptr) * addr_t'(`CORR_LAGS) + addr_t'(lag_ptr);
	assign wr_data = make_word(snap_acc[wr_addr], snap_sat[wr_addr]);

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= IDLE;
			bl_ptr <= '0;
			lag_ptr <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (tap_valid && frame_end) begin
						state <= DUMP;
						bl_ptr <= '0;
						lag_ptr <= '0;
					end
				end
				DUMP: begin
					if (wr_gnt) begin
						if (lag_ptr == lag_t'(`CORR_LAGS - 1)) begin
							lag_ptr <= '0;
							if (bl_ptr == baseline_t'(`CORR_BASELINES - 1))
								state <= DONE;
							else
								bl_ptr <= bl_ptr + 3'd1;
						end else begin
							lag_ptr <= lag_ptr + 2'd1;
						end
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/frame_reader.sv
// frame streamer: header then payload words under valid/ready with one-word prefetch
`timescale 1ns/1ps
`default_nettype none

`include "corr_config.svh"

module frame_reader import corr_frame_pkg::*; (
	input wire logic pllclk,
	input wire logic reset,
	input wire logic bank_full,
	output addr_t rd_addr,
	input wire word_t rd_data,
	input wire frame_num_t frame_num,
	input wire drop_t drop_count,
	output logic rd_release,
	output logic out_valid,
	output word_t out_data,
	output logic out_last,
	input wire logic out_ready
);

	localparam addr_t LAST = addr_t'(`CORR_FRAME_WORDS - 1);

	read_state_t state;
	addr_t ptr;  // payload word currently on rd_data
	logic load;

	assign load = (state == PAYLOAD) && (!out_valid || out_ready) && !out_last;
	assign rd_release = (state == PAYLOAD) && out_valid && out_ready && out_last;
	// look one word ahead so rd_data is ready for the next load
	assign rd_addr = (load && ptr != LAST) ? ptr + addr_t'(1) : ptr;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= WAIT;
			ptr <= '0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			case (state)
				WAIT: begin
					if (bank_full)
						state <= HEADER;
				end
				HEADER: begin
					out_valid <= 1'b1;
					state <= PAYLOAD;
				end
				PAYLOAD: begin
					if (rd_release) begin
						out_valid <= 1'b0;
						out_last <= 1'b0;
						ptr <= '0;
						state <= WAIT;
					end else if (load) begin
						out_valid <= 1'b1;
						out_last <= (ptr == LAST);
						ptr <= ptr + addr_t'(1);
					end
				end
				default: state <= WAIT;
			endcase
		end
	end

	always_ff @(posedge pllclk) begin
		if (state == HEADER)
			out_data <= {8'h00, drop_count, frame_num};
		else if (load)
			out_data <= rd_data;
	end

endmodule

`default_nettype wire

// File: logic/frame_store.sv
// round-robin write arbiter, two-bank frame memory, bank swap and drop counting
`timescale 1ns/1ps
`default_nettype none

`include "corr_config.svh"

module frame_store import corr_frame_pkg::*; (
	input wire logic pllclk,
	input wire logic reset,
	input wire logic c_req,
	input wire addr_t c_addr,
	input wire word_t c_data,
	output logic c_gnt,
	input wire logic a_req,
	input wire addr_t a_addr,
	input wire word_t a_data,
	output logic a_gnt,
	input wire logic c_done,
	input wire logic a_done,
	output logic bank_full,
	input wire addr_t rd_addr,
	output word_t rd_data,
	input wire logic rd_release,
	output frame_num_t frame_num,
	output drop_t drop_count
);

	word_t mem [2][`CORR_FRAME_WORDS];
	frame_num_t hdr_num [2];
	drop_t hdr_drop [2];

	logic last_a;  // auto engine had the last grant
	logic [1:0] full;
	bank_t wr_bank, rd_bank, target;
	logic wr_ok;  // current frame has a bank to land in
	logic c_seen, a_seen, complete, target_busy;
	frame_num_t frame_cnt;
	drop_t drop_cnt;
	addr_t w_addr;
	word_t w_data;

	assign c_gnt = c_req && (!a_req || last_a);
	assign a_gnt = a_req && !c_gnt;
	assign w_addr = c_gnt ? c_addr : a_addr;
	assign w_data = c_gnt ? c_data : a_data;

	assign complete = (c_done || c_seen) && (a_done || a_seen);
	// a dropped frame retries the same bank
	assign target = wr_ok ? ~wr_bank : wr_bank;
	assign target_busy = full[target] && !(rd_release && rd_bank == target);

	assign bank_full = full[rd_bank];
	assign frame_num = hdr_num[rd_bank];
	assign drop_count = hdr_drop[rd_bank];

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			last_a <= 1'b0;
			full <= '0;
			wr_bank <= 1'b0;
			rd_bank <= 1'b0;
			wr_ok <= 1'b1;
			c_seen <= 1'b0;
			a_seen <= 1'b0;
			frame_cnt <= '0;
			drop_cnt <= '0;
		end else begin
			if (c_gnt || a_gnt)
				last_a <= a_gnt;
			if (rd_release) begin
				full[rd_bank] <= 1'b0;
				rd_bank <= ~rd_bank;
			end
			if (complete) begin
				c_seen <= 1'b0;
				a_seen <= 1'b0;
				if (wr_ok)
					full[wr_bank] <= 1'b1;
				else
					drop_cnt <= drop_cnt + 8'd1;
				frame_cnt <= frame_cnt + 16'd1;  // dropped frames still take a number
				wr_bank <= target;
				wr_ok <= !target_busy;
			end else begin
				if (c_done)
					c_seen <= 1'b1;
				if (a_done)
					a_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if ((c_gnt || a_gnt) && wr_ok)
			mem[wr_bank][w_addr] <= w_data;
		if (complete && wr_ok) begin
			hdr_num[wr_bank] <= frame_cnt;
			hdr_drop[wr_bank] <= drop_cnt;
		end
		rd_data <= mem[rd_bank][rd_addr];
	end

endmodule

`default_nettype wire

// File: logic/sample_front.sv
// input register, three-sample delay taps per line and integration counter
`timescale 1ns/1ps
`default_nettype none

`include "corr_config.svh"

module sample_front import corr_sample_pkg::*; (
	input wire logic pllclk,
	input wire logic reset,
	input wire logic smp_valid,
	input wire lane_samples_t samples,
	input wire count_t int_len,
	output logic tap_valid,
	output tap_t [`CORR_INPUTS-1:0] taps,
	output logic frame_end
);

	count_t smp_cnt;
	logic last_smp;

	// int_len-th sample of the integration
	assign last_smp = (smp_cnt >= int_len - 16'd1);

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			tap_valid <= 1'b0;
			frame_end <= 1'b0;
			smp_cnt <= '0;
			taps <= '0;  // defined delay history for the first frame
		end else begin
			tap_valid <= smp_valid;
			frame_end <= smp_valid && last_smp;
			if (smp_valid) begin
				if (last_smp)
					smp_cnt <= '0;
				else
					smp_cnt <= smp_cnt + 16'd1;
				for (int i = 0; i < `CORR_INPUTS; i++) begin
					// newest sample enters at delay 0
					taps[i] <= {taps[i][2*`CORR_SAMPLE_W-1:0],
						samples[i*`CORR_SAMPLE_W +: `CORR_SAMPLE_W]};
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the correlator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module correlator_tb -f src.f -o correlator_sim \
	&& ./obj_dir/correlator_sim | tee /dev/stderr | grep -q "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: src.f
+incdir+logic
logic/corr_sample_pkg.sv
logic/corr_frame_pkg.sv
logic/sample_front.sv
logic/cross_engine.sv
logic/auto_engine.sv
logic/frame_store.sv
logic/frame_reader.sv
logic/correlator_top.sv
bench/correlator_asserts.sv
bench/correlator_tb.sv
